// ==== phy_reg_dump_top.f ====
source/phy_dump_pkg.sv
source/mdc_clock_gen.sv
source/mdio_read_engine.sv
source/phy_reg_bank.sv
source/mem_dump_writer.sv
source/phy_reg_dump_top.sv
verification/phy_dump_sva.sv
verification/mdio_phy_model.sv
verification/phy_dump_checker.sv
verification/phy_reg_dump_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the testbench with Verilator, run it, decide on the log
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal \
	--top-module phy_reg_dump_tb \
	-f phy_reg_dump_top.f \
	-o phy_reg_dump_sim

# the run may stop early on an assertion, the log decides
./obj_dir/phy_reg_dump_sim > sim.log 2>&1 || true
cat sim.log

if grep -q -x -F "=== PASS ===" sim.log; then
	exit 0
fi
echo "simulation failed, see sim.log"
exit 1

// ==== source/mdc_clock_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

// MDC is a plain register output of the rx clock domain. The rest of the
// design never clocks on it and only looks at mdc_rise.
module mdc_clock_gen import phy_dump_pkg::*; (
	input  wire  ENETA_RX_CLK,
	input  wire  CPU_RESETn,
	output logic mdc,
	output logic mdc_rise
);

	logic [MDC_CNT_W-1:0] half_cnt;      // position inside the half period
	logic                 half_end;

	assign half_end = (half_cnt == MDC_CNT_W'(MDC_HALF_PERIOD - 1));

	always_ff @(posedge ENETA_RX_CLK) begin
		if (!CPU_RESETn) begin
			half_cnt <= '0;
			mdc      <= 1'b0;            // idle low
			mdc_rise <= 1'b0;
		end else begin
			mdc_rise <= 1'b0;
			if (half_end) begin
				half_cnt <= '0;
				mdc      <= ~mdc;
				mdc_rise <= ~mdc;        // high together with mdc going high
			end else begin
				half_cnt <= half_cnt + MDC_CNT_W'(1);
			end
		end
	end

endmodule

`default_nettype wire

// ==== source/mdio_read_engine.sv ====
`timescale 1ns/1ps
`default_nettype none

// Sweeps all PHY registers with MDIO read frames.
// Outputs change only in mdc_rise cycles, so they are stable around every
// rising MDC edge the PHY samples on. The PHY answers after the falling
// edge, so the bit seen on a rise belongs to the slot that just closed.
module mdio_read_engine import phy_dump_pkg::*; (
	input  wire           ENETA_RX_CLK,
	input  wire           CPU_RESETn,
	input  wire           mdc_rise,
	input  wire           mdio_in,
	output logic          mdio_out,
	output logic          mdio_oe,
	output logic          cap_valid,
	output phy_reg_addr_t cap_addr,
	output phy_reg_data_t cap_data
);

	typedef enum logic [2:0] {
		ST_WAIT,                 // power-up wait
		ST_PRE,                  // preamble ones
		ST_CMD,                  // start, opcode, addresses
		ST_TA,                   // turnaround
		ST_DATA,                 // phy drives register value
		ST_DONE
	} eng_state_t;

	eng_state_t              state;
	logic [SLOT_CNT_W-1:0]   bit_cnt;       // slot inside the current field
	phy_reg_addr_t           reg_idx;       // register being read
	logic                    cap_pend;      // last data bit arrives on next rise
	logic [CMD_BITS-1:0]     cmd_sr;
	phy_reg_data_t           data_sr;

	logic pre_last;
	logic cmd_last;
	logic ta_last;
	logic data_last;

	assign pre_last  = (bit_cnt == SLOT_CNT_W'(PREAMBLE_BITS - 1));
	assign cmd_last  = (bit_cnt == SLOT_CNT_W'(CMD_BITS - 1));
	assign ta_last   = (bit_cnt == SLOT_CNT_W'(TA_BITS - 1));
	assign data_last = (bit_cnt == SLOT_CNT_W'(DATA_BITS - 1));

	//////////////////////////////////////////////////////////////////////
	// frame sequencer
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge ENETA_RX_CLK) begin
		if (!CPU_RESETn) begin
			state     <= ST_WAIT;
			bit_cnt   <= '0;
			reg_idx   <= '0;
			mdio_out  <= 1'b1;
			mdio_oe   <= 1'b0;           // pin released
			cap_pend  <= 1'b0;
			cap_valid <= 1'b0;
		end else begin
			cap_valid <= 1'b0;
			if (mdc_rise) begin
				// deliver once the final data bit has been seen
				if (cap_pend) begin
					cap_valid <= 1'b1;
					cap_pend  <= 1'b0;
				end
				bit_cnt <= bit_cnt + SLOT_CNT_W'(1);
				case (state)
					ST_WAIT: begin
						if (bit_cnt == SLOT_CNT_W'(PHY_READY_WAIT - 1)) begin
							state   <= ST_PRE;
							bit_cnt <= '0;
						end
					end
					ST_PRE: begin
						mdio_oe  <= 1'b1;
						mdio_out <= 1'b1;
						if (pre_last) begin
							state   <= ST_CMD;
							bit_cnt <= '0;
						end
					end
					ST_CMD: begin
						mdio_oe  <= 1'b1;
						mdio_out <= cmd_sr[CMD_BITS-1];    // msb first
						if (cmd_last) begin
							state   <= ST_TA;
							bit_cnt <= '0;
						end
					end
					ST_TA: begin
						mdio_oe <= 1'b0;
						if (ta_last) begin
							state   <= ST_DATA;
							bit_cnt <= '0;
						end
					end
					ST_DATA: begin
						mdio_oe <= 1'b0;
						if (data_last) begin
							bit_cnt  <= '0;
							cap_pend <= 1'b1;
							if (reg_idx == phy_reg_addr_t'(NUM_PHY_REGS - 1)) begin
								state <= ST_DONE;
							end else begin
								reg_idx <= reg_idx + phy_reg_addr_t'(1);
								state   <= ST_PRE;   // next preamble overlaps delivery
							end
						end
					end
					default: begin
						bit_cnt <= '0;           // sweep finished, stay quiet
					end
				endcase
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// command and data shift registers
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge ENETA_RX_CLK) begin
		if (mdc_rise) begin
			if (state == ST_PRE && pre_last) begin
				cmd_sr <= {MDIO_START_READ, PHY_ADDR, reg_idx};
			end else if (state == ST_CMD) begin
				cmd_sr <= {cmd_sr[CMD_BITS-2:0], 1'b0};
			end
			// first sample is the turnaround zero, it falls off the top
			if (state == ST_DATA) begin
				data_sr <= {data_sr[DATA_BITS-2:0], mdio_in};
			end
			if (cap_pend) begin
				cap_data <= {data_sr[DATA_BITS-2:0], mdio_in};   // d0 lands here
			end
			if (state == ST_DATA && data_last) begin
				cap_addr <= reg_idx;
			end
		end
	end

endmodule

`default_nettype wire

// ==== source/mem_dump_writer.sv ====
`timescale 1ns/1ps
`default_nettype none

// Copies the register bank into memory, one tagged word per register.
// Each word gets WRITE_HOLD strobe cycles and WRITE_GAP idle cycles.
module mem_dump_writer import phy_dump_pkg::*; (
	input  wire           ENETA_RX_CLK,
	input  wire           CPU_RESETn,
	input  wire           sweep_done,
	input  phy_reg_data_t rd_data,
	output phy_reg_addr_t rd_addr,
	output logic          mem_cs,
	output logic          mem_write,
	output mem_addr_t     mem_addr,
	output mem_word_t     mem_wdata,
	output logic          dump_done
);

	typedef enum logic [1:0] {
		WR_IDLE,
		WR_HOLD,
		WR_GAP,
		WR_DONE
	} wr_state_t;

	wr_state_t            state;
	logic [REG_CNT_W-1:0] word_idx;      // words started so far
	logic [WR_CNT_W-1:0]  tick;          // cycles spent in hold or gap
	logic                 wr_strobe;
	logic                 gap_end;
	logic                 all_issued;
	logic                 start_wr;

	// bank address runs one word ahead once a write starts, so the
	// next value is ready well before the gap ends
	assign rd_addr = word_idx[REG_CNT_W-2:0];

	assign gap_end    = (state == WR_GAP) && (tick == WR_CNT_W'(WRITE_GAP - 1));
	assign all_issued = (word_idx == REG_CNT_W'(NUM_PHY_REGS));
	assign start_wr   = ((state == WR_IDLE) && sweep_done) || (gap_end && !all_issued);

	//////////////////////////////////////////////////////////////////////
	// strobe sequencing
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge ENETA_RX_CLK) begin
		if (!CPU_RESETn) begin
			state     <= WR_IDLE;
			word_idx  <= '0;
			tick      <= '0;
			wr_strobe <= 1'b0;
			dump_done <= 1'b0;
		end else begin
			tick <= tick + WR_CNT_W'(1);
			if (start_wr) begin
				wr_strobe <= 1'b1;
				word_idx  <= word_idx + REG_CNT_W'(1);
				tick      <= '0;
				state     <= WR_HOLD;
			end else begin
				case (state)
					WR_HOLD: begin
						if (tick == WR_CNT_W'(WRITE_HOLD - 1)) begin
							wr_strobe <= 1'b0;
							tick      <= '0;
							state     <= WR_GAP;
						end
					end
					WR_GAP: begin
						if (gap_end) begin           // only after the last word
							dump_done <= 1'b1;
							state     <= WR_DONE;
						end
					end
					default: begin
						tick <= '0;
					end
				endcase
			end
		end
	end

	// word is latched at write start and held through the strobe
	always_ff @(posedge ENETA_RX_CLK) begin
		if (start_wr) begin
			mem_addr  <= mem_addr_t'(rd_addr);
			mem_wdata <= {DUMP_TAG, 3'b000, rd_addr, 4'h0, rd_data};
		end
	end

	assign mem_cs    = wr_strobe;
	assign mem_write = wr_strobe;    // write-only port

endmodule

`default_nettype wire

// ==== source/phy_dump_pkg.sv ====
`default_nettype none

package phy_dump_pkg;

	//////////////////////////////////////////////////////////////////////
	// MDIO frame constants
	//////////////////////////////////////////////////////////////////////

	localparam int unsigned NUM_PHY_REGS    = 32;        // registers per sweep
	localparam logic [4:0]  PHY_ADDR        = 5'd0;      // management address of the PHY
	localparam logic [3:0]  MDIO_START_READ = 4'b0110;   // start 01, read opcode 10
	localparam int unsigned PREAMBLE_BITS   = 32;        // all ones
	localparam int unsigned CMD_BITS        = 14;        // start, op, phy addr, reg addr
	localparam int unsigned TA_BITS         = 2;         // turnaround, pin released
	localparam int unsigned DATA_BITS       = 16;

	//////////////////////////////////////////////////////////////////////
	// timing, all counted in ENETA_RX_CLK cycles or MDC periods
	//////////////////////////////////////////////////////////////////////

	localparam int unsigned MDC_HALF_PERIOD = 4;         // rx clocks per MDC half period
	localparam int unsigned PHY_READY_WAIT  = 64;        // MDC periods after reset
	localparam int unsigned WRITE_HOLD      = 5;         // strobe high cycles
	localparam int unsigned WRITE_GAP       = 1;         // strobe low cycles between writes

	// memory word tag, top nibble of every dumped word
	localparam logic [3:0]  DUMP_TAG        = 4'hA;

	// counter widths
	localparam int unsigned MDC_CNT_W  = $clog2(MDC_HALF_PERIOD);
	// covers the power-up wait and every frame field
	localparam int unsigned SLOT_CNT_W = $clog2(PHY_READY_WAIT) + 1;
	localparam int unsigned WR_CNT_W   = $clog2(WRITE_HOLD + WRITE_GAP);
	// one more bit than a register number, so the count can reach NUM_PHY_REGS
	localparam int unsigned REG_CNT_W  = $clog2(NUM_PHY_REGS) + 1;

	//////////////////////////////////////////////////////////////////////
	// shared types
	//////////////////////////////////////////////////////////////////////

	typedef logic [$clog2(NUM_PHY_REGS)-1:0] phy_reg_addr_t;   // register number
	typedef logic [DATA_BITS-1:0]            phy_reg_data_t;   // register value
	typedef logic [11:0]                     mem_addr_t;       // memory word address

	// memory word, msb first:
	// tag[31:28], 3'b000, reg number[24:20], 4'h0, reg value[15:0]
	typedef logic [31:0]                     mem_word_t;

endpackage

`default_nettype wire

// ==== source/phy_reg_bank.sv ====
`timescale 1ns/1ps
`default_nettype none

module phy_reg_bank import phy_dump_pkg::*; (
	input  wire           ENETA_RX_CLK,
	input  wire           CPU_RESETn,
	input  wire           cap_valid,
	input  phy_reg_addr_t cap_addr,
	input  phy_reg_addr_t rd_addr,
	input  phy_reg_data_t cap_data,
	output phy_reg_data_t rd_data,
	output logic          sweep_done
);

	phy_reg_data_t regs [NUM_PHY_REGS];   // one entry per phy register
	logic          last_store;            // highest register just written

	// storage and registered read port
	always_ff @(posedge ENETA_RX_CLK) begin
		if (cap_valid) begin
			regs[cap_addr] <= cap_data;
		end
		rd_data <= regs[rd_addr];
	end

	//////////////////////////////////////////////////////////////////////
	// sweep completion
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge ENETA_RX_CLK) begin
		if (!CPU_RESETn) begin
			last_store <= 1'b0;
			sweep_done <= 1'b0;
		end else begin
			last_store <= cap_valid && (cap_addr == phy_reg_addr_t'(NUM_PHY_REGS - 1));
			if (last_store) begin
				sweep_done <= 1'b1;      // sticky until reset
			end
		end
	end

endmodule

`default_nettype wire

// ==== source/phy_reg_dump_top.sv ====
`timescale 1ns/1ps
`default_nettype none

// MDIO register dump: clock gen, read engine, register bank, memory writer
module phy_reg_dump_top import phy_dump_pkg::*; (
	input  wire            ENETA_RX_CLK,
	input  wire            CPU_RESETn,
	output wire            mdc,
	inout  wire            mdio,
	output wire            mem_cs,
	output wire            mem_write,
	output wire mem_addr_t mem_addr,
	output wire mem_word_t mem_wdata,
	output wire            dump_done
);

	wire            mdc_rise;
	wire            mdio_out;
	wire            mdio_oe;
	wire            mdio_in;
	wire            cap_valid;
	phy_reg_addr_t  cap_addr;
	phy_reg_data_t  cap_data;
	wire            sweep_done;
	phy_reg_addr_t  rd_addr;
	phy_reg_data_t  rd_data;

	//////////////////////////////////////////////////////////////////////
	// MDIO pin
	//////////////////////////////////////////////////////////////////////

	assign mdio    = mdio_oe ? mdio_out : 1'bz;    // pull-up on the board
	assign mdio_in = mdio;

	mdc_clock_gen mdc_gen_i (
		.ENETA_RX_CLK (ENETA_RX_CLK),
		.CPU_RESETn   (CPU_RESETn),
		.mdc          (mdc),
		.mdc_rise     (mdc_rise)
	);

	mdio_read_engine engine_i (
		.ENETA_RX_CLK (ENETA_RX_CLK),
		.CPU_RESETn   (CPU_RESETn),
		.mdc_rise     (mdc_rise),
		.mdio_in      (mdio_in),
		.mdio_out     (mdio_out),
		.mdio_oe      (mdio_oe),
		.cap_valid    (cap_valid),
		.cap_addr     (cap_addr),
		.cap_data     (cap_data)
	);

	phy_reg_bank bank_i (
		.ENETA_RX_CLK (ENETA_RX_CLK),
		.CPU_RESETn   (CPU_RESETn),
		.cap_valid    (cap_valid),
		.cap_addr     (cap_addr),
		.rd_addr      (rd_addr),
		.cap_data     (cap_data),
		.rd_data      (rd_data),
		.sweep_done   (sweep_done)
	);

	mem_dump_writer writer_i (
		.ENETA_RX_CLK (ENETA_RX_CLK),
		.CPU_RESETn   (CPU_RESETn),
		.sweep_done   (sweep_done),
		.rd_data      (rd_data),
		.rd_addr      (rd_addr),
		.mem_cs       (mem_cs),
		.mem_write    (mem_write),
		.mem_addr     (mem_addr),
		.mem_wdata    (mem_wdata),
		.dump_done    (dump_done)
	);

endmodule

`default_nettype wire

// ==== verification/mdio_phy_model.sv ====
`timescale 1ns/1ps
`default_nettype none

// PHY side of MDIO: samples on rising MDC, changes its data after falling MDC
module mdio_phy_model import phy_dump_pkg::*; (
	input  wire           mdc,
	inout  wire           mdio,
	input  wire           dut_oe,
	input  phy_reg_data_t reg_table [NUM_PHY_REGS],
	output int            frames_served,
	output int            model_errors
);

	logic phy_oe;
	logic phy_out;

	assign mdio = phy_oe ? phy_out : 1'bz;

	// one slot in which the DUT must have let go of the pin
	task automatic expect_released(input int reg_num, input string field);
		@(posedge mdc);
		if (dut_oe !== 1'b0) begin
			$display("model: DUT drives mdio during the %s of register %0d", field, reg_num);
			model_errors++;
		end
	endtask

	initial begin
		int                  ones;
		int                  bit_num;
		logic [CMD_BITS-1:0] cmd;
		logic [CMD_BITS-1:0] exp_cmd;
		phy_reg_data_t       value;
		phy_oe        = 1'b0;
		phy_out       = 1'b1;
		frames_served = 0;
		model_errors  = 0;
		forever begin
			ones = 0;
			do begin
				@(posedge mdc);
				if (dut_oe === 1'b1 && mdio === 1'b1) begin
					ones++;                  // driven preamble one
				end else if (dut_oe !== 1'b1) begin
					ones = 0;                // pull-up ones do not count
				end
			end while (!(dut_oe === 1'b1 && mdio === 1'b0));
			if (ones != PREAMBLE_BITS) begin
				$display("model: frame %0d has %0d preamble ones instead of %0d",
					frames_served, ones, PREAMBLE_BITS);
				model_errors++;
			end
			cmd = '0;                        // start bit zero already seen
			for (bit_num = 1; bit_num < CMD_BITS; bit_num++) begin
				@(posedge mdc);
				if (dut_oe !== 1'b1) begin
					$display("model: DUT released mdio inside the command of frame %0d",
						frames_served);
					model_errors++;
				end
				cmd = {cmd[CMD_BITS-2:0], mdio};
			end
			exp_cmd = {MDIO_START_READ, PHY_ADDR, 5'(frames_served)};
			if (cmd !== exp_cmd) begin
				$display("Fail frames: expected 0x%04h, actual 0x%04h", exp_cmd, cmd);
				model_errors++;
			end
			value = reg_table[frames_served % NUM_PHY_REGS];
			expect_released(frames_served, "turnaround");   // first slot floats
			@(negedge mdc);
			phy_oe  = 1'b1;
			phy_out = 1'b0;
			expect_released(frames_served, "turnaround");
			for (bit_num = DATA_BITS - 1; bit_num >= 0; bit_num--) begin
				@(negedge mdc);
				phy_out = value[bit_num];    // msb first
				expect_released(frames_served, "data");
			end
			frames_served++;
			@(negedge mdc);
			phy_oe = 1'b0;
		end
	end

endmodule

`default_nettype wire

// ==== verification/phy_dump_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

// Watches the memory port and the MDIO enable and scores the whole dump
module phy_dump_checker import phy_dump_pkg::*; (
	input  wire           ENETA_RX_CLK,
	input  wire           CPU_RESETn,
	input  wire           mem_cs,
	input  wire           mem_write,
	input  mem_addr_t     mem_addr,
	input  mem_word_t     mem_wdata,
	input  wire           dump_done,
	input  wire           mdio_oe,
	input  int            frames_served,
	input  int            model_errors,
	input  phy_reg_data_t reg_table [NUM_PHY_REGS],
	output int            check_count,
	output int            error_count,
	output logic          checks_done
);

	localparam int SETTLE_CYCLES = 4 * (WRITE_HOLD + WRITE_GAP);   // quiet time after done

	int reset_errs;
	int frame_errs;
	int data_errs;
	int order_errs;

	// tag, three zeros, register number, four zeros, register value
	function automatic mem_word_t expected_word(input int idx, input phy_reg_data_t value);
		return {DUMP_TAG, 3'b000, 5'(idx), 4'h0, value};
	endfunction

	task automatic report_mismatch(input string test, input logic [31:0] exp_v,
		input logic [31:0] act_v);
		$display("Fail %s: expected 0x%08h, actual 0x%08h", test, exp_v, act_v);
	endtask

	task automatic check_idle_outputs();
		check_count++;
		if (mem_cs !== 1'b0 || mem_write !== 1'b0 || dump_done !== 1'b0) begin
			$display("error: memory strobe or dump_done active around reset");
			reset_errs++;
		end
		if (mdio_oe !== 1'b0) begin
			$display("error: DUT drives mdio around reset");
			reset_errs++;
		end
	endtask

	task automatic check_write(input int k);
		mem_word_t exp_word;
		check_count++;
		if (k >= NUM_PHY_REGS) begin
			$display("error: memory write beyond the last register");
			order_errs++;
		end else begin
			exp_word = expected_word(k, reg_table[k]);
			if (mem_addr !== mem_addr_t'(k)) begin
				report_mismatch("data address", 32'(k), 32'(mem_addr));
				data_errs++;
			end
			if (mem_wdata !== exp_word) begin
				report_mismatch("data word", exp_word, mem_wdata);
				data_errs++;
			end
		end
		if (frames_served < NUM_PHY_REGS) begin
			$display("error: memory write %0d before all frames were served", k);
			order_errs++;
		end
	endtask

	initial begin
		int   writes;
		logic prev_cs;
		check_count = 0;
		error_count = 0;
		checks_done = 1'b0;
		reset_errs  = 0;
		frame_errs  = 0;
		data_errs   = 0;
		order_errs  = 0;
		@(posedge ENETA_RX_CLK);             // first edge loads reset values
		do begin
			@(posedge ENETA_RX_CLK);
			check_idle_outputs();
		end while (CPU_RESETn !== 1'b1);
		@(posedge ENETA_RX_CLK);             // first cycle out of reset
		check_idle_outputs();
		$display("test reset: %0d errors", reset_errs);

		//////////////////////////////////////////////////////////////////////
		// memory writes up to dump_done
		//////////////////////////////////////////////////////////////////////

		writes  = 0;
		prev_cs = 1'b0;
		while (dump_done !== 1'b1) begin
			@(posedge ENETA_RX_CLK);
			if (mem_cs === 1'b1 && !prev_cs) begin
				check_write(writes);
				writes++;
			end
			prev_cs = mem_cs;
		end
		check_count++;
		if (writes != NUM_PHY_REGS) begin
			$display("error: dump_done rose after %0d writes instead of %0d",
				writes, NUM_PHY_REGS);
			order_errs++;
		end
		check_count++;
		frame_errs = model_errors;
		if (frames_served != NUM_PHY_REGS) begin
			$display("error: %0d frames served instead of %0d", frames_served, NUM_PHY_REGS);
			frame_errs++;
		end
		$display("test frames: %0d served, %0d errors", frames_served, frame_errs);
		repeat (SETTLE_CYCLES) begin
			@(posedge ENETA_RX_CLK);
			if (mem_cs !== 1'b0 || dump_done !== 1'b1) begin
				$display("error: memory strobe or dump_done changed after the dump");
				order_errs++;
			end
		end
		$display("test data: %0d writes, %0d errors", writes, data_errs);
		$display("test ordering: %0d errors", order_errs);
		error_count = reset_errs + frame_errs + data_errs + order_errs;
		checks_done = 1'b1;
	end

endmodule

`default_nettype wire

// ==== verification/phy_dump_sva.sv ====
`timescale 1ns/1ps
`default_nettype none

// Strobe shape of the memory write port
module phy_dump_sva import phy_dump_pkg::*; (
	input wire       ENETA_RX_CLK,
	input wire       CPU_RESETn,
	input wire       mem_cs,
	input wire       mem_write,
	input mem_addr_t mem_addr,
	input mem_word_t mem_wdata
);

	int         fail_count = 0;
	logic [7:0] high_run;                    // strobe cycles so far
	logic [7:0] low_run;                     // idle cycles, saturating

	always_ff @(posedge ENETA_RX_CLK) begin
		if (!CPU_RESETn) begin
			high_run <= '0;
			low_run  <= '0;
		end else if (mem_cs) begin
			high_run <= high_run + 8'd1;
			low_run  <= '0;
		end else begin
			high_run <= '0;
			if (low_run != 8'hFF) begin
				low_run <= low_run + 8'd1;
			end
		end
	end

	cs_is_write: assert property (@(posedge ENETA_RX_CLK) disable iff (!CPU_RESETn)
		mem_cs == mem_write)
		else begin
			fail_count++;
			$error("mem_cs and mem_write differ");
		end

	hold_length: assert property (@(posedge ENETA_RX_CLK) disable iff (!CPU_RESETn)
		$fell(mem_cs) |-> high_run == 8'(WRITE_HOLD))
		else begin
			fail_count++;
			$error("write strobe held %0d cycles", high_run);
		end

	gap_length: assert property (@(posedge ENETA_RX_CLK) disable iff (!CPU_RESETn)
		$rose(mem_cs) |-> low_run >= 8'(WRITE_GAP))
		else begin
			fail_count++;
			$error("write strobe gap too short");
		end

	word_stable: assert property (@(posedge ENETA_RX_CLK) disable iff (!CPU_RESETn)
		mem_cs && $past(mem_cs) |-> $stable(mem_addr) && $stable(mem_wdata))
		else begin
			fail_count++;
			$error("address or data moved during a write strobe");
		end

endmodule

bind mem_dump_writer phy_dump_sva strobe_sva_i (
	.ENETA_RX_CLK (ENETA_RX_CLK),
	.CPU_RESETn   (CPU_RESETn),
	.mem_cs       (mem_cs),
	.mem_write    (mem_write),
	.mem_addr     (mem_addr),
	.mem_wdata    (mem_wdata)
);

`default_nettype wire

// ==== verification/phy_reg_dump_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module phy_reg_dump_tb import phy_dump_pkg::*; ();

	localparam int CLK_HALF   = 50;                        // 100 ns period
	localparam int MDC_CYCLES = 2 * MDC_HALF_PERIOD;
	localparam int RUN_CYCLES = (PHY_READY_WAIT + NUM_PHY_REGS * 65) * MDC_CYCLES
		+ NUM_PHY_REGS * (WRITE_HOLD + WRITE_GAP);
	localparam int WATCHDOG_CYCLES = RUN_CYCLES + RUN_CYCLES / 4 + 200;   // margin

	logic          ENETA_RX_CLK;
	logic          CPU_RESETn;
	wire           mdc;
	wire           mdio;
	wire           mem_cs;
	wire           mem_write;
	mem_addr_t     mem_addr;
	mem_word_t     mem_wdata;
	wire           dump_done;
	phy_reg_data_t reg_table [NUM_PHY_REGS];    // values the phy model returns
	int            frames_served;
	int            model_errors;
	int            check_count;
	int            error_count;
	logic          checks_done;

	pullup (mdio);

	// 16 bit fibonacci lfsr, taps 16 14 13 11
	function automatic logic [15:0] lfsr_next(input logic [15:0] state);
		return {state[14:0], state[15] ^ state[13] ^ state[12] ^ state[10]};
	endfunction

	phy_reg_dump_top dut_i (
		.ENETA_RX_CLK (ENETA_RX_CLK),
		.CPU_RESETn   (CPU_RESETn),
		.mdc          (mdc),
		.mdio         (mdio),
		.mem_cs       (mem_cs),
		.mem_write    (mem_write),
		.mem_addr     (mem_addr),
		.mem_wdata    (mem_wdata),
		.dump_done    (dump_done)
	);

	mdio_phy_model phy_i (
		.mdc           (mdc),
		.mdio          (mdio),
		.dut_oe        (dut_i.mdio_oe),
		.reg_table     (reg_table),
		.frames_served (frames_served),
		.model_errors  (model_errors)
	);

	phy_dump_checker checker_i (
		.ENETA_RX_CLK  (ENETA_RX_CLK),
		.CPU_RESETn    (CPU_RESETn),
		.mem_cs        (mem_cs),
		.mem_write     (mem_write),
		.mem_addr      (mem_addr),
		.mem_wdata     (mem_wdata),
		.dump_done     (dump_done),
		.mdio_oe       (dut_i.mdio_oe),
		.frames_served (frames_served),
		.model_errors  (model_errors),
		.reg_table     (reg_table),
		.check_count   (check_count),
		.error_count   (error_count),
		.checks_done   (checks_done)
	);

	initial begin
		ENETA_RX_CLK = 1'b0;
		forever begin
			#CLK_HALF ENETA_RX_CLK = ~ENETA_RX_CLK;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// register table, reset and final summary
	//////////////////////////////////////////////////////////////////////

	initial begin
		logic [15:0] lfsr;
		int          r;
		int          b;
		int          sva_fails;
		CPU_RESETn = 1'b0;
		lfsr = 16'd23916;
		for (r = 0; r < NUM_PHY_REGS; r++) begin
			reg_table[r] = '0;
			for (b = 0; b < DATA_BITS; b++) begin
				reg_table[r] = {reg_table[r][DATA_BITS-2:0], lfsr[15]};   // one step per bit
				lfsr = lfsr_next(lfsr);
			end
		end
		repeat (3) @(negedge ENETA_RX_CLK);
		CPU_RESETn = 1'b1;
		wait (checks_done === 1'b1);
		@(negedge ENETA_RX_CLK);
		sva_fails = dut_i.writer_i.strobe_sva_i.fail_count;
		$display("summary: %0d checks, %0d errors, %0d assertion failures",
			check_count, error_count, sva_fails);
		if (error_count == 0 && sva_fails == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

	// watchdog, sized from the power-up wait, the sweep and the dump
	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge ENETA_RX_CLK);
		$display("watchdog: dump not finished after %0d clock cycles", WATCHDOG_CYCLES);
		$display("=== FAIL ===");
		$finish;
	end

endmodule

`default_nettype wire
